// File: Bender.yml
package:
  name: model_store

export_include_dirs:
  - .

sources:
  - geom_pkg.sv
  - bus_pkg.sv
  - model_buffer.sv
  - scene_regs.sv
  - triangle_streamer.sv
  - model_store_top.sv
  - target: test
    files:
      - model_store_asserts.sv
      - tb_model_store.sv

// File: build.f
+incdir+.
geom_pkg.sv
bus_pkg.sv
model_buffer.sv
scene_regs.sv
triangle_streamer.sv
model_store_top.sv
model_store_asserts.sv
tb_model_store.sv

// File: bus_pkg.sv
`include "render_consts.svh"

package bus_pkg;

    typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [`AXIL_DATA_W-1:0] axil_data_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    // Host to register block
    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    // Register block to host
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_e bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_e rresp;
    } axil_resp_t;

endpackage

// File: geom_pkg.sv
`include "render_consts.svh"

package geom_pkg;

    typedef logic signed [`COORD_W-1:0] coord_t;

    // x sits in the low half of the word
    typedef struct packed {
        coord_t y;
        coord_t x;
    } vertex_t;

    // v0 sits in the lowest word
    typedef struct packed {
        vertex_t v2;
        vertex_t v1;
        vertex_t v0;
    } triangle_t;

    typedef logic [$clog2(`MODEL_COUNT)-1:0]      model_idx_t;
    typedef logic [$clog2(`TRIANGLE_COUNT)-1:0]   tri_idx_t;    // Index or memory address
    typedef logic [$clog2(`TRIANGLE_COUNT+1)-1:0] tri_count_t;  // Holds 0 up to the full count

    typedef enum logic [1:0] {
        MODEL_EMPTY   = 2'b00,
        MODEL_WRITING = 2'b01,
        MODEL_SEALED  = 2'b10
    } model_state_t;

endpackage

// File: model_buffer.sv
`timescale 1ns/1ps
`include "render_consts.svh"

module model_buffer import geom_pkg::*; (
    input  logic       clk,
    input  logic       rstn,

    input  logic       write_en,
    input  triangle_t  write_triangle,
    input  model_idx_t write_model,
    input  tri_idx_t   write_index,

    input  model_idx_t read_model,
    input  tri_idx_t   read_index,

    output triangle_t  read_triangle,
    output logic       read_last,
    output logic       read_model_used,
    output logic       write_refused,
    output logic       buffer_full
);

    typedef struct packed {
        model_state_t state;
        tri_idx_t     start;    // First memory slot of the model
        tri_count_t   size;     // Triangles written so far
    } model_entry_t;

    model_entry_t registry [`MODEL_COUNT];
    triangle_t    tri_mem [`TRIANGLE_COUNT];

    tri_count_t   fill_count;   // Next free slot, equals slots in use
    model_idx_t   last_model;   // Model of the last accepted write

    model_entry_t wr_entry;
    model_entry_t rd_entry;
    tri_count_t   write_addr;   // Wide enough to spot an overrun
    tri_count_t   write_end;
    tri_count_t   write_size;
    tri_count_t   read_addr;
    logic         write_legal;
    logic         write_ok;

    assign buffer_full = (fill_count == tri_count_t'(`TRIANGLE_COUNT));

    // Write legality and placement
    always_comb begin
        wr_entry = registry[write_model];

        // An empty model opens at the fill pointer
        if (wr_entry.state == MODEL_EMPTY) begin
            write_addr = fill_count + tri_count_t'(write_index);
        end else begin
            write_addr = tri_count_t'(wr_entry.start) + tri_count_t'(write_index);
        end

        write_end  = write_addr + tri_count_t'(1);
        write_size = tri_count_t'(write_index) + tri_count_t'(1);

        write_legal = (wr_entry.state != MODEL_SEALED) &&
                      !((wr_entry.state == MODEL_EMPTY) && buffer_full) &&
                      (write_addr < tri_count_t'(`TRIANGLE_COUNT));
    end

    assign write_ok      = write_en && write_legal;
    assign write_refused = write_en && !write_legal;

    // Read side
    always_comb begin
        rd_entry        = registry[read_model];
        read_addr       = tri_count_t'(rd_entry.start) + tri_count_t'(read_index);
        read_triangle   = tri_mem[tri_idx_t'(read_addr)];
        read_last       = (tri_count_t'(read_index) + tri_count_t'(1) == rd_entry.size);
        read_model_used = (rd_entry.state != MODEL_EMPTY);
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int m = 0; m < `MODEL_COUNT; m++) begin
                registry[m] <= '{state: MODEL_EMPTY, start: '0, size: '0};
            end
            fill_count <= '0;
            last_model <= '0;
        end else if (write_ok) begin
            // Moving on to another model closes the previous one for good
            if ((write_model != last_model) && (registry[last_model].state == MODEL_WRITING)) begin
                registry[last_model].state <= MODEL_SEALED;
            end

            if (wr_entry.state == MODEL_EMPTY) begin
                registry[write_model].state <= MODEL_WRITING;
                registry[write_model].start <= tri_idx_t'(fill_count);
            end

            if (write_size > wr_entry.size) begin
                registry[write_model].size <= write_size;
            end
            if (write_end > fill_count) begin
                fill_count <= write_end;
            end
            last_model <= write_model;
        end
    end

    always_ff @(posedge clk) begin
        if (write_ok) begin
            tri_mem[tri_idx_t'(write_addr)] <= write_triangle;   // Address is below 16 here
        end
    end

endmodule

// File: model_store_asserts.sv
`timescale 1ns/1ps

module model_store_asserts import geom_pkg::*, bus_pkg::*; (
    input logic       clk,
    input logic       rstn,
    input axil_req_t  axil_req,
    input axil_resp_t axil_resp,
    input logic       busy,
    input logic       tri_valid,
    input logic       tri_ready,
    input triangle_t  tri_data,
    input logic       tri_last
);

    int error_count = 0;    // Read by the testbench

    // Write response waits for the host
    bvalid_held: assert property (@(posedge clk) disable iff (!rstn)
        axil_resp.bvalid && !axil_req.bready |=> axil_resp.bvalid && $stable(axil_resp.bresp))
        else begin
            $error("bvalid dropped or bresp changed before bready");
            error_count++;
        end

    // Read data waits for the host
    rvalid_held: assert property (@(posedge clk) disable iff (!rstn)
        axil_resp.rvalid && !axil_req.rready |=> axil_resp.rvalid && $stable(axil_resp.rdata))
        else begin
            $error("rvalid dropped or rdata changed before rready");
            error_count++;
        end

    stream_stable: assert property (@(posedge clk) disable iff (!rstn)
        tri_valid && !tri_ready |=> tri_valid && $stable(tri_data) && $stable(tri_last))
        else begin
            $error("Stream changed while stalled");
            error_count++;
        end

    valid_needs_busy: assert property (@(posedge clk) disable iff (!rstn)
        tri_valid |-> busy)
        else begin
            $error("tri_valid high while the streamer is idle");
            error_count++;
        end

    // Draw ends right after the last transfer
    last_ends_draw: assert property (@(posedge clk) disable iff (!rstn)
        tri_valid && tri_ready && tri_last |=> !tri_valid && !busy)
        else begin
            $error("Stream still active after the last triangle");
            error_count++;
        end

endmodule

bind model_store_top model_store_asserts u_asserts (.*);

// File: model_store_top.sv
`timescale 1ns/1ps

module model_store_top import geom_pkg::*, bus_pkg::*; (
    input  logic       clk,
    input  logic       rstn,

    input  axil_req_t  axil_req,
    output axil_resp_t axil_resp,

    input  logic       tri_ready,
    output logic       tri_valid,
    output triangle_t  tri_data,
    output logic       tri_last
);

    // Register block to buffer
    logic       write_en;
    triangle_t  write_triangle;
    model_idx_t write_model;
    tri_idx_t   write_index;
    logic       write_refused;
    logic       buffer_full;

    // Register block to streamer
    logic       draw_start;
    model_idx_t draw_model;
    logic       busy;

    // Streamer to buffer
    model_idx_t read_model;
    tri_idx_t   read_index;
    triangle_t  read_triangle;
    logic       read_last;
    logic       read_model_used;

    scene_regs u_regs (
        .clk           (clk),
        .rstn          (rstn),
        .axil_req      (axil_req),
        .axil_resp     (axil_resp),
        .write_refused (write_refused),
        .buffer_full   (buffer_full),
        .busy          (busy),
        .write_en      (write_en),
        .write_triangle(write_triangle),
        .write_model   (write_model),
        .write_index   (write_index),
        .draw_start    (draw_start),
        .draw_model    (draw_model)
    );

    model_buffer u_buffer (
        .clk            (clk),
        .rstn           (rstn),
        .write_en       (write_en),
        .write_triangle (write_triangle),
        .write_model    (write_model),
        .write_index    (write_index),
        .read_model     (read_model),
        .read_index     (read_index),
        .read_triangle  (read_triangle),
        .read_last      (read_last),
        .read_model_used(read_model_used),
        .write_refused  (write_refused),
        .buffer_full    (buffer_full)
    );

    triangle_streamer u_streamer (
        .clk            (clk),
        .rstn           (rstn),
        .draw_start     (draw_start),
        .draw_model     (draw_model),
        .read_model     (read_model),
        .read_index     (read_index),
        .read_triangle  (read_triangle),
        .read_last      (read_last),
        .read_model_used(read_model_used),
        .busy           (busy),
        .tri_valid      (tri_valid),
        .tri_data       (tri_data),
        .tri_last       (tri_last),
        .tri_ready      (tri_ready)
    );

endmodule

// File: render_consts.svh
`ifndef RENDER_CONSTS_SVH
`define RENDER_CONSTS_SVH

// Scene capacities, fixed per build since the register map encodes the index fields
`define MODEL_COUNT    4
`define TRIANGLE_COUNT 16

`define COORD_W        16   // One signed screen coordinate

// AXI4-Lite bus widths
`define AXIL_ADDR_W    8
`define AXIL_DATA_W    32

// Register offsets
`define REG_VERT0      8'h00
`define REG_VERT1      8'h04
`define REG_VERT2      8'h08
`define REG_WRITE_CMD  8'h0C   // Model in 1:0, triangle index in 11:8
`define REG_DRAW_CMD   8'h10   // Model in 1:0
`define REG_STATUS     8'h14   // Busy, full, refused

`endif

// File: scene_regs.sv
`timescale 1ns/1ps
`include "render_consts.svh"

module scene_regs import geom_pkg::*, bus_pkg::*; (
    input  logic       clk,
    input  logic       rstn,

    input  axil_req_t  axil_req,
    output axil_resp_t axil_resp,

    input  logic       write_refused,
    input  logic       buffer_full,
    input  logic       busy,

    output logic       write_en,
    output triangle_t  write_triangle,
    output model_idx_t write_model,
    output tri_idx_t   write_index,

    output logic       draw_start,
    output model_idx_t draw_model
);

    vertex_t    vert_q [3];     // Staged vertices of the next triangle
    logic       refused_q;      // Sticky write-refused flag

    logic       bvalid_q;
    axil_resp_e bresp_q;
    logic       rvalid_q;
    axil_data_t rdata_q;
    axil_resp_e rresp_q;

    logic       wr_fire;
    logic       rd_fire;
    logic       wr_cmd;
    logic       wr_draw;
    axil_data_t rd_word;

    function automatic logic is_mapped(axil_addr_t addr);
        case (addr)
            `REG_VERT0, `REG_VERT1, `REG_VERT2,
            `REG_WRITE_CMD, `REG_DRAW_CMD, `REG_STATUS: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Address and data are taken together, one response outstanding
    assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign rd_fire = axil_req.arvalid && !rvalid_q;

    assign wr_cmd  = wr_fire && (axil_req.awaddr == `REG_WRITE_CMD);
    assign wr_draw = wr_fire && (axil_req.awaddr == `REG_DRAW_CMD);

    assign write_triangle = {vert_q[2], vert_q[1], vert_q[0]};

    always_comb begin
        axil_resp.awready = wr_fire;
        axil_resp.wready  = wr_fire;
        axil_resp.bvalid  = bvalid_q;
        axil_resp.bresp   = bresp_q;
        axil_resp.arready = rd_fire;
        axil_resp.rvalid  = rvalid_q;
        axil_resp.rdata   = rdata_q;
        axil_resp.rresp   = rresp_q;
    end

    // Read mux, command registers read as zero
    always_comb begin
        rd_word = '0;
        case (axil_req.araddr)
            `REG_VERT0:  rd_word = vert_q[0];
            `REG_VERT1:  rd_word = vert_q[1];
            `REG_VERT2:  rd_word = vert_q[2];
            `REG_STATUS: rd_word = axil_data_t'({refused_q, buffer_full, busy});
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bvalid_q    <= 1'b0;
            rvalid_q    <= 1'b0;
            write_en    <= 1'b0;
            draw_start  <= 1'b0;
            refused_q   <= 1'b0;
            write_model <= '0;
            write_index <= '0;
            draw_model  <= '0;
        end else begin
            write_en   <= wr_cmd;     // One-cycle pulses
            draw_start <= wr_draw;

            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end

            if (rd_fire) begin
                rvalid_q <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end

            if (wr_cmd) begin
                write_model <= model_idx_t'(axil_req.wdata[1:0]);
                write_index <= tri_idx_t'(axil_req.wdata[11:8]);
            end
            if (wr_draw) begin
                draw_model <= model_idx_t'(axil_req.wdata[1:0]);
            end

            // Refusal arrives with write_en, a cycle after the clearing command
            if (write_refused) begin
                refused_q <= 1'b1;
            end else if (wr_cmd) begin
                refused_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            if (is_mapped(axil_req.awaddr)) begin
                bresp_q <= RESP_OKAY;
            end else begin
                bresp_q <= RESP_SLVERR;
            end
            case (axil_req.awaddr)
                `REG_VERT0: vert_q[0] <= axil_req.wdata;
                `REG_VERT1: vert_q[1] <= axil_req.wdata;
                `REG_VERT2: vert_q[2] <= axil_req.wdata;
                default: ;                  // Status and holes ignore writes
            endcase
        end

        if (rd_fire) begin
            rdata_q <= rd_word;
            if (is_mapped(axil_req.araddr)) begin
                rresp_q <= RESP_OKAY;
            end else begin
                rresp_q <= RESP_SLVERR;
            end
        end
    end

endmodule

// File: tb_model_store.sv
`timescale 1ns/1ps
`include "render_consts.svh"

module tb_model_store import geom_pkg::*, bus_pkg::*; ();

    localparam int WAIT_LIMIT = 200;    // Cycles per wait loop

    logic       clk;
    logic       rstn;
    axil_req_t  axil_req;
    axil_resp_t axil_resp;
    logic       tri_ready;
    logic       tri_valid;
    triangle_t  tri_data;
    logic       tri_last;

    triangle_t  expected_tris [`MODEL_COUNT][`TRIANGLE_COUNT];   // Scoreboard per model
    int         expected_count [`MODEL_COUNT];

    model_store_top DUT (
        .clk      (clk),
        .rstn     (rstn),
        .axil_req (axil_req),
        .axil_resp(axil_resp),
        .tri_ready(tri_ready),
        .tri_valid(tri_valid),
        .tri_data (tri_data),
        .tri_last (tri_last)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [95:0] expected,
                               input logic [95:0] actual);
        assert (actual === expected) else begin
            $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            fail_run("Value mismatch");
        end
    endtask

    // Stop at the first failed bus or stream assertion
    always @(negedge clk) begin
        if (DUT.u_asserts.error_count != 0) begin
            fail_run("A bus or stream assertion failed");
        end
    end

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              output axil_resp_e resp);
        int waited;
        waited = 0;
        @(negedge clk);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        #1;                                 // Let awready settle mid-phase
        while (!(axil_resp.awready && axil_resp.wready)) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("Timeout waiting for awready and wready");
            end
            @(negedge clk);
            #1;
        end
        @(negedge clk);                     // Taken on the edge just passed
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        waited = 0;
        while (!axil_resp.bvalid) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("Timeout waiting for bvalid");
            end
            @(negedge clk);
        end
        repeat ($urandom % 3) @(negedge clk);   // Host is slow to take the response at times
        resp = axil_resp.bresp;
        axil_req.bready = 1'b1;
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output axil_resp_e resp);
        int waited;
        waited = 0;
        @(negedge clk);
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        #1;
        while (!axil_resp.arready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("Timeout waiting for arready");
            end
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        waited = 0;
        while (!axil_resp.rvalid) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("Timeout waiting for rvalid");
            end
            @(negedge clk);
        end
        repeat ($urandom % 3) @(negedge clk);   // Read data may sit a while
        data = axil_resp.rdata;
        resp = axil_resp.rresp;
        axil_req.rready = 1'b1;
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    task automatic write_reg(input axil_addr_t addr, input axil_data_t data);
        axil_resp_e resp;
        axil_write(addr, data, resp);
        check_value("bresp", RESP_OKAY, resp);
    endtask

    task automatic read_reg(input axil_addr_t addr, output axil_data_t data);
        axil_resp_e resp;
        axil_read(addr, data, resp);
        check_value("rresp", RESP_OKAY, resp);
    endtask

    // Stage a random triangle, commit it and check the refused flag
    task automatic load_triangle(input model_idx_t model, input tri_idx_t index,
                                 input logic refused);
        triangle_t  new_tri;
        axil_data_t status;
        new_tri = {$urandom, $urandom, $urandom};
        write_reg(`REG_VERT0, new_tri.v0);
        write_reg(`REG_VERT1, new_tri.v1);
        write_reg(`REG_VERT2, new_tri.v2);
        write_reg(`REG_WRITE_CMD, {20'd0, index, 6'd0, model});
        read_reg(`REG_STATUS, status);
        check_value("status.refused", refused, status[2]);
        if (!refused) begin
            expected_tris[model][index] = new_tri;
            if (int'(index) + 1 > expected_count[model]) begin
                expected_count[model] = int'(index) + 1;
            end
        end
    endtask

    task automatic wait_idle();
        axil_data_t status;
        int         waited;
        waited = 0;
        read_reg(`REG_STATUS, status);
        while (status[0]) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("Timeout waiting for busy to clear");
            end
            read_reg(`REG_STATUS, status);
        end
    endtask

    task automatic draw_and_check(input model_idx_t model, input logic random_ready,
                                  input logic check_busy);
        axil_data_t status;
        int         k;
        int         waited;
        logic       done;
        k      = 0;
        waited = 0;
        done   = 1'b0;
        tri_ready = 1'b0;                   // Hold the first triangle on the output
        write_reg(`REG_DRAW_CMD, 32'(model));
        if (check_busy) begin
            read_reg(`REG_STATUS, status);
            check_value("status.busy", 1'b1, status[0]);
        end
        while (!done) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("Timeout waiting for the triangle stream");
            end
            tri_ready = random_ready ? (($urandom % 3) != 0) : 1'b1;
            if (tri_valid && tri_ready) begin   // Transfer on the coming edge
                check_value("tri_data", expected_tris[model][k], tri_data);
                check_value("tri_last", k == expected_count[model] - 1, tri_last);
                done = tri_last;
                k++;
            end
        end
        wait_idle();
    endtask

    task automatic expect_no_stream(input model_idx_t model);
        write_reg(`REG_DRAW_CMD, 32'(model));
        repeat (8) begin
            @(negedge clk);
            check_value("tri_valid", 1'b0, tri_valid);
        end
        wait_idle();
    endtask

    initial begin
        axil_data_t value;
        axil_resp_e resp;
        triangle_t  staged;
        void'($urandom(83));
        clk       = 1'b0;
        rstn      = 1'b0;
        axil_req  = '0;
        tri_ready = 1'b0;
        for (int m = 0; m < `MODEL_COUNT; m++) begin
            expected_count[m] = 0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        read_reg(`REG_STATUS, value);
        check_value("status", 32'd0, value);

        // Holes answer SLVERR, status ignores writes
        axil_write(8'h18, 32'hdead_beef, resp);
        check_value("bresp", RESP_SLVERR, resp);
        axil_read(8'h1C, value, resp);
        check_value("rresp", RESP_SLVERR, resp);
        write_reg(`REG_STATUS, 32'h7);
        read_reg(`REG_STATUS, value);
        check_value("status", 32'd0, value);

        staged = {$urandom, $urandom, $urandom};
        write_reg(`REG_VERT0, staged.v0);
        write_reg(`REG_VERT1, staged.v1);
        write_reg(`REG_VERT2, staged.v2);
        read_reg(`REG_VERT0, value);
        check_value("vert0", staged.v0, value);
        read_reg(`REG_VERT1, value);
        check_value("vert1", staged.v1, value);
        read_reg(`REG_VERT2, value);
        check_value("vert2", staged.v2, value);

        for (int i = 0; i < 3; i++) begin
            load_triangle(2'd0, tri_idx_t'(i), 1'b0);
        end
        for (int i = 0; i < 5; i++) begin
            load_triangle(2'd1, tri_idx_t'(i), 1'b0);   // Seals model 0
        end
        draw_and_check(2'd0, 1'b0, 1'b0);
        draw_and_check(2'd1, 1'b0, 1'b0);

        // Back-pressure
        draw_and_check(2'd1, 1'b1, 1'b0);
        draw_and_check(2'd0, 1'b1, 1'b0);

        load_triangle(2'd0, 4'd3, 1'b1);
        draw_and_check(2'd0, 1'b1, 1'b0);

        // Fill the memory with model 2
        for (int i = 0; i < 7; i++) begin
            load_triangle(2'd2, tri_idx_t'(i), 1'b0);
        end
        read_reg(`REG_STATUS, value);
        check_value("status.full", 1'b0, value[1]);
        load_triangle(2'd2, 4'd7, 1'b0);
        read_reg(`REG_STATUS, value);
        check_value("status.full", 1'b1, value[1]);
        load_triangle(2'd3, 4'd0, 1'b1);
        expect_no_stream(2'd3);
        draw_and_check(2'd2, 1'b1, 1'b0);

        draw_and_check(2'd1, 1'b1, 1'b1);

        if (DUT.u_asserts.error_count != 0) begin
            fail_run("A bus or stream assertion failed");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: triangle_streamer.sv
`timescale 1ns/1ps

module triangle_streamer import geom_pkg::*; (
    input  logic       clk,
    input  logic       rstn,

    input  logic       draw_start,
    input  model_idx_t draw_model,

    output model_idx_t read_model,
    output tri_idx_t   read_index,
    input  triangle_t  read_triangle,
    input  logic       read_last,
    input  logic       read_model_used,

    output logic       busy,
    output logic       tri_valid,
    output triangle_t  tri_data,
    output logic       tri_last,
    input  logic       tri_ready
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,     // Register the first triangle
        S_SEND       // Hold output until taken
    } stream_state_t;

    stream_state_t state;
    model_idx_t    cur_model;
    tri_idx_t      cur_index;   // Index of the triangle on the output
    logic          load_out;

    assign busy       = (state != S_IDLE);
    assign tri_valid  = (state == S_SEND);
    assign read_model = cur_model;

    // While sending, look one triangle ahead so the next one is ready on transfer
    assign read_index = (state == S_SEND) ? tri_idx_t'(cur_index + 1'b1) : cur_index;

    assign load_out = ((state == S_FETCH) && read_model_used) ||
                      ((state == S_SEND) && tri_ready && !tri_last);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= S_IDLE;
            cur_model <= '0;
            cur_index <= '0;
            tri_last  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (draw_start) begin       // Ignored while busy
                        cur_model <= draw_model;
                        cur_index <= '0;
                        state     <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (read_model_used) begin
                        tri_last <= read_last;
                        state    <= S_SEND;
                    end else begin
                        state <= S_IDLE;        // Nothing to draw
                    end
                end
                S_SEND: begin
                    if (tri_ready) begin
                        if (tri_last) begin
                            state <= S_IDLE;
                        end else begin
                            cur_index <= cur_index + 1'b1;
                            tri_last  <= read_last;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            tri_data <= read_triangle;
        end
    end

endmodule
